/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_prg_inject
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/inject_checker.sv */
// Watches the PRG injection DUT and compares its writes and key words with the expected queues
`default_nettype none
`timescale 1ns/10ps

module inject_checker #(
	parameter int MEM_ADDR_W = 25
) (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  wire                   io_cycle_i,
	input  wire                   dl_wait_i,
	input  wire                   mem_ce_i,
	input  wire                   mem_we_i,
	input  wire [MEM_ADDR_W-1:0]  mem_addr_i,
	input  wire [7:0]             mem_data_i,
	input  wire [10:0]            key_i
);

	logic [MEM_ADDR_W-1:0] addr_q [$];
	logic [7:0] data_q [$];
	logic [10:0] key_q [$];
	string test_name = "none";
	int write_errs = 0;
	int key_errs = 0;
	int proto_errs = 0;
	// Sampled history of the DUT ports
	logic ce_prev = 1'b0;
	logic io_h1 = 1'b0;
	logic io_h2 = 1'b0;
	logic reset_d = 1'b0;
	logic key_armed = 1'b0;
	logic [10:0] key_prev = '0;

	task automatic set_test(input string name);
		test_name = name;
	endtask

	task automatic expect_write(input logic [MEM_ADDR_W-1:0] addr, input logic [7:0] data);
		addr_q.push_back(addr);
		data_q.push_back(data);
	endtask

	task automatic expect_key(input logic [10:0] word);
		key_q.push_back(word);
	endtask

	function automatic int pending_count();
		return addr_q.size() + key_q.size();
	endfunction

	function automatic int keys_left();
		return key_q.size();
	endfunction

	// ====================
	// Memory side
	always @(posedge clk_sys) begin
		logic [MEM_ADDR_W-1:0] exp_addr;
		logic [7:0] exp_data;
		// Unknown levels count as not reset
		if (reset_n && !reset_d &&
			(dl_wait_i !== 1'b0 || mem_ce_i !== 1'b0 || mem_we_i !== 1'b0)) begin
			proto_errs++;
			$display("[%s] dl_wait, mem_ce or mem_we is not low right after reset", test_name);
		end
		if (reset_n && mem_we_i && !mem_ce_i) begin
			proto_errs++;
			$display("[%s] mem_we is high without mem_ce", test_name);
		end
		if (reset_n && mem_ce_i && !ce_prev) begin
			// A write starts one cycle after io_cycle goes from high to low
			if (!(io_h2 && !io_h1) || !mem_we_i) begin
				proto_errs++;
				$display("[%s] write at %h was not issued in an opened slot", test_name, mem_addr_i);
			end
			if (addr_q.size() == 0) begin
				write_errs++;
				$display("[%s] unexpected memory write of %h at %h", test_name, mem_data_i, mem_addr_i);
			end else begin
				exp_addr = addr_q.pop_front();
				exp_data = data_q.pop_front();
				if (mem_addr_i !== exp_addr || mem_data_i !== exp_data) begin
					write_errs++;
					$display("** Error [%s] write: expected %h <= %h, actual %h <= %h",
						test_name, exp_addr, exp_data, mem_addr_i, mem_data_i);
				end
			end
		end
		ce_prev = mem_ce_i;
		io_h2 = io_h1;
		io_h1 = io_cycle_i;
		reset_d = reset_n;
	end

	// ====================
	// Keyboard side
	always @(posedge clk_sys) begin
		logic [10:0] exp_key;
		if (key_armed && key_i !== key_prev) begin
			if (key_q.size() == 0) begin
				key_errs++;
				$display("[%s] key word changed to %h with nothing expected", test_name, key_i);
			end else begin
				exp_key = key_q.pop_front();
				if (key_i !== exp_key) begin
					key_errs++;
					$display("** Error [%s] key: expected %h, actual %h", test_name, exp_key, key_i);
				end
			end
		end
		if (reset_n) begin
			key_armed = 1'b1;
		end
		key_prev = key_i;
	end

endmodule

`default_nettype wire

/* bench/tb_prg_inject.sv */
// Testbench for PRG injection, random downloads and slot timing, checked by inject_checker
`default_nettype none
`timescale 1ns/10ps

module tb_prg_inject;

	localparam int MEM_ADDR_W = inject_pkg::MEM_ADDR_W_DEFAULT;
	localparam int STEP_CYCLES = 32;
	localparam int NUM_DL = 4;

	logic clk_sys;
	logic reset_n;
	logic dl_active_i;
	logic [7:0] dl_index_i;
	logic dl_wr_i;
	logic [15:0] dl_addr_i;
	logic [7:0] dl_data_i;
	logic io_cycle_i;
	logic [10:0] ps2_key_i;
	wire dl_wait_o;
	wire mem_ce_o;
	wire mem_we_o;
	wire [MEM_ADDR_W-1:0] mem_addr_o;
	wire [7:0] mem_data_o;
	wire [10:0] key_o;

	logic [15:0] stim_lfsr = 16'd61;
	logic [15:0] slot_lfsr = 16'd61;
	logic [15:0] load_addr [NUM_DL];
	int dl_len [NUM_DL];
	int wd_cycles = 0;

	prg_inject_top #(
		.MEM_ADDR_W(MEM_ADDR_W),
		.STEP_CYCLES(STEP_CYCLES)
	) prg_inject_top_i (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.dl_wait_o   (dl_wait_o),
		.io_cycle_i  (io_cycle_i),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.ps2_key_i   (ps2_key_i),
		.key_o       (key_o)
	);

	inject_checker #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) checker_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.dl_wait_i  (dl_wait_o),
		.mem_ce_i   (mem_ce_o),
		.mem_we_i   (mem_we_o),
		.mem_addr_i (mem_addr_o),
		.mem_data_i (mem_data_o),
		.key_i      (key_o)
	);

	// ====================
	// Random source
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] stim_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_step(stim_lfsr);
			v = {v[14:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// ====================
	// Reference model
	function automatic logic [7:0] typed_code(input int step);
		case (step)
			1, 5: return 8'h12;
			2: return 8'h6C;
			7: return 8'h2D;
			9: return 8'h3C;
			11: return 8'h31;
			13: return 8'h5A;
			default: return 8'h00;
		endcase
	endfunction

	// Odd steps press and even steps release, a new code clears the whole word
	task automatic typing_words(input int steps);
		logic [10:0] word;
		logic [7:0] code;
		word = '0;
		for (int s = 1; s <= steps; s++) begin
			code = typed_code(s);
			if (code != 8'h00) begin
				word = {3'b000, code};
			end
			word[9] = (s % 2) == 1;
			checker_i.expect_key(word);
		end
	endtask

	task automatic pointer_writes(input logic [15:0] end_addr);
		checker_i.expect_write(MEM_ADDR_W'(8'h2B), 8'h01);
		checker_i.expect_write(MEM_ADDR_W'(8'h2C), 8'h08);
		checker_i.expect_write(MEM_ADDR_W'(8'h2D), end_addr[7:0]);
		checker_i.expect_write(MEM_ADDR_W'(8'h2E), end_addr[15:8]);
		checker_i.expect_write(MEM_ADDR_W'(8'h2F), end_addr[7:0]);
		checker_i.expect_write(MEM_ADDR_W'(8'h30), end_addr[15:8]);
		checker_i.expect_write(MEM_ADDR_W'(8'h31), end_addr[7:0]);
		checker_i.expect_write(MEM_ADDR_W'(8'h32), end_addr[15:8]);
		checker_i.expect_write(MEM_ADDR_W'(8'hAC), 8'h00);
		checker_i.expect_write(MEM_ADDR_W'(8'hAD), 8'h00);
		checker_i.expect_write(MEM_ADDR_W'(8'hAE), end_addr[7:0]);
		checker_i.expect_write(MEM_ADDR_W'(8'hAF), end_addr[15:8]);
	endtask

	// Passthrough words keep bit 10 set so they never match a typed word
	task automatic change_key();
		logic [15:0] r;
		logic [10:0] k;
		r = stim_bits(10);
		k = {1'b1, r[9:0]};
		if (k == ps2_key_i) begin
			k[0] = ~k[0];
		end
		ps2_key_i = k;
		checker_i.expect_key(k);
	endtask

	task automatic run_download(input logic [7:0] index, input int n, input int steps);
		logic [15:0] r;
		logic [15:0] end_addr;
		logic [7:0] data;
		logic is_prg;
		is_prg = (index[7:6] == 2'b00) && (index[5:0] == 6'd4);
		end_addr = load_addr[n];
		dl_index_i = index;
		dl_active_i = 1'b1;
		next_cycle();
		for (int i = 0; i < dl_len[n] + 2; i++) begin
			if (i < 2) begin
				data = (i == 0) ? load_addr[n][7:0] : load_addr[n][15:8];
			end else begin
				r = stim_bits(8);
				data = r[7:0];
				if (is_prg) begin
					checker_i.expect_write(MEM_ADDR_W'(end_addr), data);
				end
				end_addr = end_addr + 16'd1;
			end
			dl_wr_i = 1'b1;
			dl_addr_i = 16'(i);
			dl_data_i = data;
			next_cycle();
			dl_wr_i = 1'b0;
			while (dl_wait_o) begin
				next_cycle();
			end
			r = stim_bits(2);
			repeat (r[1:0]) next_cycle();
		end
		dl_active_i = 1'b0;
		if (is_prg) begin
			pointer_writes(end_addr);
			typing_words(steps);
			checker_i.expect_key(ps2_key_i);
		end
	endtask

	task automatic wait_drained();
		while (checker_i.pending_count() != 0) begin
			next_cycle();
		end
		repeat (4) next_cycle();
	endtask

	// ====================
	// Clock, slot timing and watchdog
	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		io_cycle_i = 1'b1;
		forever begin
			next_cycle();
			slot_lfsr = lfsr_step(slot_lfsr);
			io_cycle_i = slot_lfsr[0];
		end
	end

	initial begin
		wait (wd_cycles != 0);
		repeat (wd_cycles) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int bytes;
		int errs;
		logic [15:0] r;
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i = 8'h00;
		dl_wr_i = 1'b0;
		dl_addr_i = 16'h0000;
		dl_data_i = 8'h00;
		ps2_key_i = 11'h400;
		bytes = 0;
		for (int i = 0; i < NUM_DL; i++) begin
			load_addr[i] = stim_bits(16);
			r = stim_bits(6);
			dl_len[i] = 8 + int'(r[5:0]) % 33;
			// Header, data and the page-zero walk
			bytes += dl_len[i] + 2 + 256;
		end
		// One typing window per download plus one after the reset
		wd_cycles = bytes * 64 + (NUM_DL + 1) * 16 * STEP_CYCLES + 2000;
		repeat (16) next_cycle();
		reset_n = 1'b1;

		checker_i.set_test("passthrough");
		repeat (6) begin
			change_key();
			r = stim_bits(2);
			repeat (1 + r[1:0]) next_cycle();
		end
		wait_drained();

		checker_i.set_test("prg_load");
		run_download(8'h04, 0, 15);
		wait_drained();

		checker_i.set_test("non_prg");
		run_download(8'hC4, 1, 15);
		repeat (300 + 16 * STEP_CYCLES) next_cycle();
		wait_drained();

		checker_i.set_test("prg_reload");
		run_download(8'h04, 2, 15);
		wait_drained();

		// Reset lands inside the fourth typing step
		checker_i.set_test("reset_typing");
		run_download(8'h04, 3, 3);
		while (checker_i.keys_left() > 1) begin
			next_cycle();
		end
		repeat (4) next_cycle();
		reset_n = 1'b0;
		repeat (16) next_cycle();
		reset_n = 1'b1;
		repeat (4) begin
			change_key();
			repeat (3) next_cycle();
		end
		repeat (16 * STEP_CYCLES + 100) next_cycle();
		wait_drained();

		errs = checker_i.write_errs + checker_i.key_errs + checker_i.proto_errs;
		$display("Errors: %0d write, %0d key, %0d protocol", checker_i.write_errs,
			checker_i.key_errs, checker_i.proto_errs);
		if (errs == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/autostart_typer.sv */
// Types clear-screen and RUN after a load, otherwise passes keyboard codes through
`default_nettype none
`timescale 1ns/10ps

module autostart_typer #(
	parameter int STEP_CYCLES = 640000
) (
	input  wire                               clk_sys,
	input  wire                               reset_n,
	input  wire                               start_i,
	input  wire [keyboard_pkg::KEY_W-1:0]     ps2_key_i,
	output logic [keyboard_pkg::KEY_W-1:0]    key_o
);

	localparam int CNT_W = (STEP_CYCLES > 1) ? $clog2(STEP_CYCLES) : 1;

	keyboard_pkg::type_step_e step_q;
	logic [CNT_W-1:0] cnt_q;
	logic code_load;
	logic [keyboard_pkg::KEY_CODE_W-1:0] code;

	// Codes loaded at the end of a step
	always_comb begin
		code_load = 1'b1;
		code = '0;
		case (step_q)
			keyboard_pkg::STEP_1: code = keyboard_pkg::KEY_SHIFT;
			keyboard_pkg::STEP_2: code = keyboard_pkg::KEY_HOME;
			// Shift again so it does not stay stuck
			keyboard_pkg::STEP_5: code = keyboard_pkg::KEY_SHIFT;
			keyboard_pkg::STEP_7: code = keyboard_pkg::KEY_R;
			keyboard_pkg::STEP_9: code = keyboard_pkg::KEY_U;
			keyboard_pkg::STEP_11: code = keyboard_pkg::KEY_N;
			keyboard_pkg::STEP_13: code = keyboard_pkg::KEY_RETURN;
			default: code_load = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			step_q <= keyboard_pkg::STEP_0;
			cnt_q <= '0;
			key_o <= ps2_key_i;
		end else if (start_i) begin
			step_q <= keyboard_pkg::STEP_1;
			cnt_q <= '0;
		end else if (step_q == keyboard_pkg::STEP_0) begin
			cnt_q <= '0;
			key_o <= ps2_key_i;
		end else if (cnt_q == CNT_W'(STEP_CYCLES - 1)) begin
			cnt_q <= '0;
			if (step_q == keyboard_pkg::STEP_15) begin
				step_q <= keyboard_pkg::STEP_0;
			end else begin
				step_q <= keyboard_pkg::type_step_e'(step_q + 4'd1);
			end
			// Odd steps press, even steps release
			if (code_load) begin
				key_o <= '0;
				key_o[keyboard_pkg::KEY_CODE_W-1:0] <= code;
			end
			key_o[keyboard_pkg::KEY_PRESS_BIT] <= step_q[0];
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	// The loader finishes one meminit before another can start
	a_start_when_idle: assert property (@(posedge clk_sys) disable iff (!reset_n)
		start_i |-> step_q == keyboard_pkg::STEP_0);

endmodule

`default_nettype wire

/* rtl/inject_pkg.sv */
// Shared file kinds, loader states, page-zero pointer table and widths for PRG injection
`default_nettype none

package inject_pkg;

	// ====================
	// Download decoding
	typedef enum logic [7:0] {
		PRG   = 8'd4,
		OTHER = 8'hFF
	} file_kind_e;

	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		DATA,
		MEMINIT
	} loader_state_e;

	// Index of a PRG file, upper two index bits must be zero
	localparam logic [5:0] PRG_INDEX = 6'd4;

	// ====================
	// Widths
	localparam int MEM_ADDR_W_DEFAULT = 25;
	localparam int DL_ADDR_W = 16;
	localparam int PRG_ADDR_W = 16;
	localparam int DATA_W = 8;

	// ====================
	// BASIC pointers in page zero
	localparam logic [8:0] MEMINIT_END = 9'd256;

	localparam logic [7:0] PTR_TXT_LO = 8'h2B;
	localparam logic [7:0] PTR_TXT_HI = 8'h2C;
	localparam logic [7:0] PTR_VAR_LO = 8'h2D;
	localparam logic [7:0] PTR_VAR_HI = 8'h2E;
	localparam logic [7:0] PTR_ARY_LO = 8'h2F;
	localparam logic [7:0] PTR_ARY_HI = 8'h30;
	localparam logic [7:0] PTR_STR_LO = 8'h31;
	localparam logic [7:0] PTR_STR_HI = 8'h32;
	localparam logic [7:0] PTR_SAVE_LO = 8'hAC;
	localparam logic [7:0] PTR_SAVE_HI = 8'hAD;
	localparam logic [7:0] PTR_END_LO = 8'hAE;
	localparam logic [7:0] PTR_END_HI = 8'hAF;

	// Values left by a reset, LOAD does not touch these
	localparam logic [7:0] TXT_LO_VAL = 8'h01;
	localparam logic [7:0] TXT_HI_VAL = 8'h08;
	localparam logic [7:0] SAVE_VAL = 8'h00;

endpackage

`default_nettype wire

/* rtl/keyboard_pkg.sv */
// PS/2 scan codes, key word layout and typing steps used by the autostart typer
`default_nettype none

package keyboard_pkg;

	// ====================
	// Key word layout
	// Bit 9 is the press flag, bits 7..0 the scan code, bits 10 and 8 pass through
	localparam int KEY_W = 11;
	localparam int KEY_PRESS_BIT = 9;
	localparam int KEY_CODE_W = 8;

	// ====================
	// Scan codes
	localparam logic [7:0] KEY_SHIFT = 8'h12;
	localparam logic [7:0] KEY_HOME = 8'h6C;
	localparam logic [7:0] KEY_R = 8'h2D;
	localparam logic [7:0] KEY_U = 8'h3C;
	localparam logic [7:0] KEY_N = 8'h31;
	localparam logic [7:0] KEY_RETURN = 8'h5A;

	// Step 0 is idle
	typedef enum logic [3:0] {
		STEP_0, STEP_1, STEP_2, STEP_3,
		STEP_4, STEP_5, STEP_6, STEP_7,
		STEP_8, STEP_9, STEP_10, STEP_11,
		STEP_12, STEP_13, STEP_14, STEP_15
	} type_step_e;

endpackage

`default_nettype wire

/* rtl/mem_write_slot.sv */
// Holds one memory write and issues it in the next slot granted by the core
`default_nettype none
`timescale 1ns/10ps

module mem_write_slot #(
	parameter int MEM_ADDR_W = inject_pkg::MEM_ADDR_W_DEFAULT
) (
	input  wire                              clk_sys,
	input  wire                              reset_n,
	input  wire                              io_cycle_i,
	input  wire                              wr_req_i,
	input  wire [MEM_ADDR_W-1:0]             wr_addr_i,
	input  wire [inject_pkg::DATA_W-1:0]     wr_data_i,
	output logic                             busy_o,
	output logic                             mem_ce_o,
	output logic                             mem_we_o,
	output logic [MEM_ADDR_W-1:0]            mem_addr_o,
	output logic [inject_pkg::DATA_W-1:0]    mem_data_o
);

	logic io_cycle_d;
	logic slot_open;
	logic slot_closed;
	logic [MEM_ADDR_W-1:0] pend_addr_q;
	logic [inject_pkg::DATA_W-1:0] pend_data_q;

	// Falling edge of io_cycle opens a slot, two high cycles close it
	assign slot_open = io_cycle_d & ~io_cycle_i;
	assign slot_closed = io_cycle_d & io_cycle_i;

	always_ff @(posedge clk_sys) begin
		if (wr_req_i) begin
			pend_addr_q <= wr_addr_i;
			pend_data_q <= wr_data_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_cycle_d <= 1'b0;
			busy_o <= 1'b0;
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
		end else begin
			io_cycle_d <= io_cycle_i;
			if (wr_req_i) begin
				busy_o <= 1'b1;
			end
			// A write needs the previous slot closed first
			if (slot_open && busy_o && !mem_ce_o) begin
				mem_ce_o <= 1'b1;
				mem_we_o <= 1'b1;
				mem_addr_o <= pend_addr_q;
				mem_data_o <= pend_data_q;
				busy_o <= 1'b0;
			end
			if (slot_closed) begin
				mem_ce_o <= 1'b0;
				mem_we_o <= 1'b0;
			end
		end
	end

	// Only one write can be held, a new request must wait until it is issued
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!reset_n)
		wr_req_i |-> !busy_o);

endmodule

`default_nettype wire

/* rtl/prg_inject_top.sv */
// Top level of PRG injection, connects the loader, memory write slot and autostart typer
`default_nettype none
`timescale 1ns/10ps

module prg_inject_top #(
	parameter int MEM_ADDR_W = inject_pkg::MEM_ADDR_W_DEFAULT,
	parameter int STEP_CYCLES = 640000
) (
	input  wire                               clk_sys,
	input  wire                               reset_n,
	// Download source
	input  wire                               dl_active_i,
	input  wire [7:0]                         dl_index_i,
	input  wire                               dl_wr_i,
	input  wire [inject_pkg::DL_ADDR_W-1:0]   dl_addr_i,
	input  wire [inject_pkg::DATA_W-1:0]      dl_data_i,
	output wire                               dl_wait_o,
	// Memory side
	input  wire                               io_cycle_i,
	output wire                               mem_ce_o,
	output wire                               mem_we_o,
	output wire [MEM_ADDR_W-1:0]              mem_addr_o,
	output wire [inject_pkg::DATA_W-1:0]      mem_data_o,
	// Keyboard
	input  wire [keyboard_pkg::KEY_W-1:0]     ps2_key_i,
	output wire [keyboard_pkg::KEY_W-1:0]     key_o
);

	wire busy;
	wire wr_req;
	wire [MEM_ADDR_W-1:0] wr_addr;
	wire [inject_pkg::DATA_W-1:0] wr_data;
	wire meminit_done;

	prg_loader #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) prg_loader_i (
		.clk_sys        (clk_sys),
		.reset_n        (reset_n),
		.dl_active_i    (dl_active_i),
		.dl_index_i     (dl_index_i),
		.dl_wr_i        (dl_wr_i),
		.dl_addr_i      (dl_addr_i),
		.dl_data_i      (dl_data_i),
		.busy_i         (busy),
		.dl_wait_o      (dl_wait_o),
		.wr_req_o       (wr_req),
		.wr_addr_o      (wr_addr),
		.wr_data_o      (wr_data),
		.meminit_done_o (meminit_done)
	);

	mem_write_slot #(
		.MEM_ADDR_W(MEM_ADDR_W)
	) mem_write_slot_i (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.wr_req_i   (wr_req),
		.wr_addr_i  (wr_addr),
		.wr_data_i  (wr_data),
		.busy_o     (busy),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

	autostart_typer #(
		.STEP_CYCLES(STEP_CYCLES)
	) autostart_typer_i (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.start_i   (meminit_done),
		.ps2_key_i (ps2_key_i),
		.key_o     (key_o)
	);

endmodule

`default_nettype wire

/* rtl/prg_loader.sv */
// Parses a PRG download into memory write requests, then rewrites the BASIC pointers
`default_nettype none
`timescale 1ns/10ps

module prg_loader #(
	parameter int MEM_ADDR_W = inject_pkg::MEM_ADDR_W_DEFAULT
) (
	input  wire                                clk_sys,
	input  wire                                reset_n,
	input  wire                                dl_active_i,
	input  wire [7:0]                          dl_index_i,
	input  wire                                dl_wr_i,
	input  wire [inject_pkg::DL_ADDR_W-1:0]    dl_addr_i,
	input  wire [inject_pkg::DATA_W-1:0]       dl_data_i,
	input  wire                                busy_i,
	output logic                               dl_wait_o,
	output logic                               wr_req_o,
	output logic [MEM_ADDR_W-1:0]              wr_addr_o,
	output logic [inject_pkg::DATA_W-1:0]      wr_data_o,
	output logic                               meminit_done_o
);

	inject_pkg::file_kind_e kind;
	inject_pkg::loader_state_e state_q;

	logic dl_active_d;
	// Next data address, ends up as the end address of the program
	logic [inject_pkg::PRG_ADDR_W-1:0] end_addr_q;
	logic [8:0] meminit_addr_q;
	logic ptr_hit;
	logic [inject_pkg::DATA_W-1:0] ptr_data;

	assign kind = (dl_index_i[7:6] == 2'b00 && dl_index_i[5:0] == inject_pkg::PRG_INDEX) ?
		inject_pkg::PRG : inject_pkg::OTHER;

	// Hold the source off while a write is requested or pending
	assign dl_wait_o = busy_i | wr_req_o;

	// ====================
	// Pointer table lookup
	always_comb begin
		ptr_hit = 1'b1;
		ptr_data = '0;
		case (meminit_addr_q[7:0])
			inject_pkg::PTR_TXT_LO: ptr_data = inject_pkg::TXT_LO_VAL;
			inject_pkg::PTR_TXT_HI: ptr_data = inject_pkg::TXT_HI_VAL;
			inject_pkg::PTR_SAVE_LO,
			inject_pkg::PTR_SAVE_HI: ptr_data = inject_pkg::SAVE_VAL;
			inject_pkg::PTR_VAR_LO,
			inject_pkg::PTR_ARY_LO,
			inject_pkg::PTR_STR_LO,
			inject_pkg::PTR_END_LO: ptr_data = end_addr_q[7:0];
			inject_pkg::PTR_VAR_HI,
			inject_pkg::PTR_ARY_HI,
			inject_pkg::PTR_STR_HI,
			inject_pkg::PTR_END_HI: ptr_data = end_addr_q[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ====================
	// Download and meminit FSM
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			state_q <= inject_pkg::IDLE;
			dl_active_d <= 1'b0;
			wr_req_o <= 1'b0;
			meminit_done_o <= 1'b0;
			meminit_addr_q <= '0;
		end else begin
			dl_active_d <= dl_active_i;
			wr_req_o <= 1'b0;
			meminit_done_o <= 1'b0;

			case (state_q)
				inject_pkg::IDLE: begin
					if (dl_active_i && kind == inject_pkg::PRG) begin
						state_q <= inject_pkg::HEADER;
					end
				end
				inject_pkg::HEADER, inject_pkg::DATA: begin
					if (dl_wr_i) begin
						if (dl_addr_i == '0) begin
							end_addr_q[7:0] <= dl_data_i;
						end else if (dl_addr_i == inject_pkg::DL_ADDR_W'(1)) begin
							end_addr_q[15:8] <= dl_data_i;
							state_q <= inject_pkg::DATA;
						end else if (state_q == inject_pkg::DATA) begin
							wr_req_o <= 1'b1;
							wr_addr_o <= MEM_ADDR_W'(end_addr_q);
							wr_data_o <= dl_data_i;
							end_addr_q <= end_addr_q + 1'b1;
						end
					end
					if (dl_active_d && !dl_active_i) begin
						state_q <= inject_pkg::MEMINIT;
						meminit_addr_q <= '0;
					end
				end
				inject_pkg::MEMINIT: begin
					// One address per cycle, pointers wait for their write
					if (!wr_req_o && !busy_i) begin
						if (meminit_addr_q == inject_pkg::MEMINIT_END) begin
							state_q <= inject_pkg::IDLE;
							meminit_done_o <= 1'b1;
						end else begin
							if (ptr_hit) begin
								wr_req_o <= 1'b1;
								wr_addr_o <= MEM_ADDR_W'(meminit_addr_q[7:0]);
								wr_data_o <= ptr_data;
							end
							meminit_addr_q <= meminit_addr_q + 1'b1;
						end
					end
				end
				default: state_q <= inject_pkg::IDLE;
			endcase
		end
	end

	// A new request must never overrun the one held in the write slot
	a_no_req_when_busy: assert property (@(posedge clk_sys) disable iff (!reset_n)
		$rose(wr_req_o) |-> !busy_i);

endmodule

`default_nettype wire

/* src.f */
rtl/inject_pkg.sv
rtl/keyboard_pkg.sv
rtl/prg_loader.sv
rtl/mem_write_slot.sv
rtl/autostart_typer.sv
rtl/prg_inject_top.sv
bench/inject_checker.sv
bench/tb_prg_inject.sv
